// File: kronos_testdata.txt
# P addr word = program word, D addr word = initial data word, text after the word is free
# S addr value = expected store in program order, hex fields, addresses are byte addresses
P 00000000 00500093  addi x1, x0, 5
P 00000004 ffc00113  addi x2, x0, -4
P 00000008 002081b3  add  x3, x1, x2
P 0000000c 40208233  sub  x4, x1, x2
P 00000010 123452b7  lui  x5, 0x12345
P 00000014 0012c333  xor  x6, x5, x1
P 00000018 001263b3  or   x7, x4, x1
P 0000001c 00237433  and  x8, x6, x2
P 00000020 00700013  addi x0, x0, 7
P 00000024 dead0537  lui  x10, 0xdead0
P 00000028 20302023  sw   x3, 0x200(x0)
P 0000002c 20402223  sw   x4, 0x204(x0)
P 00000030 20602423  sw   x6, 0x208(x0)
P 00000034 20702623  sw   x7, 0x20c(x0)
P 00000038 20802823  sw   x8, 0x210(x0)
P 0000003c 20002a23  sw   x0, 0x214(x0)
P 00000040 10002483  lw   x9, 0x100(x0)
P 00000044 001484b3  add  x9, x9, x1
P 00000048 10902023  sw   x9, 0x100(x0)
P 0000004c 00308663  beq  x1, x3, +12  not taken
P 00000050 00109463  bne  x1, x1, +8   not taken
P 00000054 20102c23  sw   x1, 0x218(x0)
P 00000058 00108463  beq  x1, x1, +8   taken
P 0000005c 20a02e23  sw   x10, 0x21c(x0)  wrong path
P 00000060 00309463  bne  x1, x3, +8   taken
P 00000064 20a02e23  sw   x10, 0x21c(x0)  wrong path
P 00000068 008005ef  jal  x11, +8
P 0000006c 20a02e23  sw   x10, 0x21c(x0)  wrong path
P 00000070 22b02023  sw   x11, 0x220(x0)
P 00000074 0000006f  jal  x0, 0
D 00000100 00c0ffee
S 00000200 00000001
S 00000204 00000009
S 00000208 12345005
S 0000020c 0000000d
S 00000210 12345004
S 00000214 00000000
S 00000100 00c0fff3
S 00000218 00000005
S 00000220 0000006c

// File: kronos.f
kronos_types.sv
kronos_if.sv
kronos_id.sv
kronos_ex.sv
kronos_core.sv
kronos_bus_arbiter.sv
kronos_soc.sv
kronos_tb.sv

// File: kronos_tb.sv
/* Testbench for the RV32I subset SoC. Memory model with random acknowledge delays,
   bus protocol checks and an in-order store monitor, all fed from kronos_testdata.txt. */
`timescale 1ns/1ps
`default_nettype none

module kronos_tb;

  localparam int FIRST_REQ_LIMIT = 20;
  localparam int STORE_LIMIT = 4000;
  localparam int QUIET_CYCLES = 60;

  logic clk = 1'b0;
  logic rst;
  kronos_types::word_t mem_addr;
  kronos_types::word_t mem_wr_data;
  kronos_types::mask_t mem_mask;
  logic mem_wr_en;
  logic mem_req;
  kronos_types::word_t mem_rd_data;
  logic mem_ack = 1'b0;

  // Byte-addressed word memory and the expected store sequence
  kronos_types::word_t mem [kronos_types::word_t];
  kronos_types::word_t exp_addr [$];
  kronos_types::word_t exp_data [$];

  int check_count = 0;
  int error_count = 0;
  int fault_count = 0;
  int timeout_count = 0;
  int store_total = 0;
  int store_seen = 0;

  // Request captured at its first cycle
  logic busy = 1'b0;
  int delay;
  kronos_types::word_t cap_addr;
  kronos_types::word_t cap_data;
  logic cap_wr;

  kronos_soc uut (
    .clk(clk),
    .rst(rst),
    .mem_addr(mem_addr),
    .mem_wr_data(mem_wr_data),
    .mem_mask(mem_mask),
    .mem_wr_en(mem_wr_en),
    .mem_req(mem_req),
    .mem_rd_data(mem_rd_data),
    .mem_ack(mem_ack)
  );

  always #10 clk = ~clk;

  // ====================
  // Compare tasks
  // ====================
  task automatic check_word(input string name, input kronos_types::word_t got,
                            input kronos_types::word_t expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %08h expected %08h", $time, name, got, expected);
    end
  endtask

  task automatic check_mask(input string name, input kronos_types::mask_t got,
                            input kronos_types::mask_t expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %04b expected %04b", $time, name, got, expected);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, expected);
    end
  endtask

  // ====================
  // Test data
  // ====================
  task automatic load_testdata();
    int fd;
    int code;
    string line;
    byte kind;
    kronos_types::word_t a;
    kronos_types::word_t v;
    fd = $fopen("kronos_testdata.txt", "r");
    if (fd == 0) begin
      fault_count++;
      $display("Could not open kronos_testdata.txt for reading");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      // Short lines are blank, # starts a comment line
      if (code > 0 && line.len() > 2 && line[0] != "#") begin
        code = $sscanf(line, "%c %h %h", kind, a, v);
        if (code == 3 && (kind == "P" || kind == "D")) begin
          mem[a] = v;
        end else if (code == 3 && kind == "S") begin
          exp_addr.push_back(a);
          exp_data.push_back(v);
        end else begin
          fault_count++;
          $display("Unreadable line in kronos_testdata.txt: %s", line);
        end
      end
    end
    $fclose(fd);
  endtask

  // ====================
  // Memory model
  // ====================
  task automatic record_store(input kronos_types::word_t addr, input kronos_types::word_t data);
    if (exp_addr.size() == 0) begin
      fault_count++;
      $display("Unexpected store at t=%0t to address %08h with value %08h", $time, addr, data);
    end else begin
      check_word("mem_addr of store", addr, exp_addr.pop_front());
      check_word("mem_wr_data of store", data, exp_data.pop_front());
      store_seen++;
    end
  endtask

  task automatic complete_access();
    if (cap_wr) begin
      record_store(cap_addr, cap_data);
      mem[cap_addr] = cap_data;
    end else begin
      // Unloaded words read as zero, which decodes as a no-op
      mem_rd_data = mem.exists(cap_addr) ? mem[cap_addr] : '0;
    end
    mem_ack = 1'b1;
  endtask

  // Acknowledge after 0 to 3 extra cycles, drawn per request
  initial begin
    int seed;
    seed = $urandom(32'hf880323b);
    forever begin
      @(negedge clk);
      if (mem_ack) begin
        // Acknowledge lasts one cycle
        mem_ack = 1'b0;
        busy = 1'b0;
      end else if (mem_req) begin
        if (!busy) begin
          busy = 1'b1;
          cap_addr = mem_addr;
          cap_data = mem_wr_data;
          cap_wr = mem_wr_en;
          delay = $urandom % 4;
        end else begin
          check_word("mem_addr", mem_addr, cap_addr);
          check_word("mem_wr_data", mem_wr_data, cap_data);
          check_bit("mem_wr_en", mem_wr_en, cap_wr);
        end
        if (cap_wr) check_mask("mem_mask", mem_mask, 4'hf);
        if (delay == 0) complete_access();
        else delay--;
      end else if (busy) begin
        fault_count++;
        $display("Bus fault at t=%0t: mem_req dropped before mem_ack", $time);
        busy = 1'b0;
      end
    end
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    int cycles;
    rst = 1'b1;
    mem_rd_data = '0;
    load_testdata();
    store_total = exp_addr.size();
    if (store_total == 0) begin
      fault_count++;
      $display("No expected stores found in kronos_testdata.txt");
    end

    // Reset for three cycles, no request may appear
    repeat (3) begin
      @(negedge clk);
      check_bit("mem_req", mem_req, 1'b0);
    end
    rst = 1'b0;
    @(negedge clk);
    check_bit("mem_req", mem_req, 1'b0);

    cycles = 0;
    while (!mem_req && cycles < FIRST_REQ_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!mem_req) begin
      timeout_count++;
      $display("Timeout: no memory request within %0d cycles after reset", FIRST_REQ_LIMIT);
    end else begin
      // Program starts at address zero
      check_word("mem_addr", mem_addr, 32'h0000_0000);
      check_bit("mem_wr_en", mem_wr_en, 1'b0);
    end

    cycles = 0;
    while (store_seen < store_total && cycles < STORE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (store_seen < store_total) begin
      timeout_count++;
      $display("Timeout: only %0d of %0d expected stores after %0d cycles",
               store_seen, store_total, STORE_LIMIT);
    end

    // Quiet window to catch stray stores
    repeat (QUIET_CYCLES) @(negedge clk);

    $display("Summary: %0d checks, %0d mismatches, %0d faults, %0d timeouts, %0d/%0d stores",
             check_count, error_count, fault_count, timeout_count, store_seen, store_total);
    if (error_count == 0 && fault_count == 0 && timeout_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: kronos_soc.sv
/* Design top: the core and the bus arbiter, exposing a single memory port. */
`timescale 1ns/1ps
`default_nettype none

module kronos_soc (
  input  logic                clk,
  input  logic                rst,
  output kronos_types::word_t mem_addr,
  output kronos_types::word_t mem_wr_data,
  output kronos_types::mask_t mem_mask,
  output logic                mem_wr_en,
  output logic                mem_req,
  input  kronos_types::word_t mem_rd_data,
  input  logic                mem_ack
);

  kronos_types::word_t instr_addr;
  kronos_types::word_t instr_data;
  logic instr_req;
  logic instr_ack;

  kronos_types::word_t data_addr;
  kronos_types::word_t data_wr_data;
  kronos_types::word_t data_rd_data;
  kronos_types::mask_t data_mask;
  logic data_wr_en;
  logic data_req;
  logic data_ack;

  kronos_core u_core (.*);

  kronos_bus_arbiter u_arb (.*);

endmodule

`default_nettype wire

// File: kronos_bus_arbiter.sv
/* Joins the instruction and data masters onto one memory port.
   Data wins a tie and a grant lasts until the memory acknowledges. */
`timescale 1ns/1ps
`default_nettype none

module kronos_bus_arbiter (
  input  logic                clk,
  input  logic                rst,
  // Instruction master side
  input  kronos_types::word_t instr_addr,
  input  logic                instr_req,
  output kronos_types::word_t instr_data,
  output logic                instr_ack,
  // Data master side
  input  kronos_types::word_t data_addr,
  input  kronos_types::word_t data_wr_data,
  input  kronos_types::mask_t data_mask,
  input  logic                data_wr_en,
  input  logic                data_req,
  output kronos_types::word_t data_rd_data,
  output logic                data_ack,
  // Memory port
  output kronos_types::word_t mem_addr,
  output kronos_types::word_t mem_wr_data,
  output kronos_types::mask_t mem_mask,
  output logic                mem_wr_en,
  output logic                mem_req,
  input  kronos_types::word_t mem_rd_data,
  input  logic                mem_ack
);

  kronos_types::arb_state_t state;
  logic sel_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= kronos_types::ARB_IDLE;
    end else begin
      case (state)
        kronos_types::ARB_IDLE: begin
          if (data_req) state <= kronos_types::ARB_SERVE_DATA;
          else if (instr_req) state <= kronos_types::ARB_SERVE_INSTR;
        end
        default: begin
          if (mem_ack) state <= kronos_types::ARB_IDLE;
        end
      endcase
    end
  end

  // Granted master drives the port
  assign sel_data = state == kronos_types::ARB_SERVE_DATA;
  assign mem_req = state != kronos_types::ARB_IDLE;
  assign mem_addr = sel_data ? data_addr : instr_addr;
  assign mem_wr_data = sel_data ? data_wr_data : '0;
  assign mem_mask = sel_data ? data_mask : '1;
  assign mem_wr_en = sel_data && data_wr_en;

  assign instr_ack = mem_ack && (state == kronos_types::ARB_SERVE_INSTR);
  assign data_ack = mem_ack && sel_data;
  assign instr_data = mem_rd_data;
  assign data_rd_data = mem_rd_data;

endmodule

`default_nettype wire

// File: kronos_core.sv
/* Core top: fetch, decode and execute chained by valid/ready, with separate
   instruction and data bus masters. */
`timescale 1ns/1ps
`default_nettype none

module kronos_core (
  input  logic                clk,
  input  logic                rst,
  // Instruction master
  output kronos_types::word_t instr_addr,
  output logic                instr_req,
  input  kronos_types::word_t instr_data,
  input  logic                instr_ack,
  // Data master
  output kronos_types::word_t data_addr,
  output kronos_types::word_t data_wr_data,
  output kronos_types::mask_t data_mask,
  output logic                data_wr_en,
  output logic                data_req,
  input  kronos_types::word_t data_rd_data,
  input  logic                data_ack
);

  kronos_types::word_t fetch_instr;
  kronos_types::word_t fetch_pc;
  logic fetch_vld;
  logic fetch_rdy;

  kronos_types::ex_kind_t ex_kind;
  kronos_types::alu_op_t alu_op;
  kronos_types::word_t operand_a;
  kronos_types::word_t operand_b;
  kronos_types::word_t store_data;
  kronos_types::word_t decode_target;
  kronos_types::word_t link_pc;
  kronos_types::regsel_t rd;
  logic rd_en;
  logic decode_vld;
  logic decode_rdy;

  kronos_types::word_t regwr_data;
  kronos_types::regsel_t regwr_sel;
  logic regwr_en;
  kronos_types::word_t branch_target;
  logic branch;
  logic flush;

  // A taken branch squashes everything younger than execute
  assign flush = branch;

  // ====================
  // Stages
  // ====================
  kronos_if u_if (.*);

  kronos_id u_id (
    .branch_target(decode_target),
    .*
  );

  kronos_ex u_ex (.*);

endmodule

`default_nettype wire

// File: kronos_ex.sv
/* Execute stage: ALU, branch resolution, word loads and stores on the data bus,
   and the write-back and branch strobes. */
`timescale 1ns/1ps
`default_nettype none

module kronos_ex (
  input  logic                    clk,
  input  logic                    rst,
  input  kronos_types::ex_kind_t  ex_kind,
  input  kronos_types::alu_op_t   alu_op,
  input  kronos_types::word_t     operand_a,
  input  kronos_types::word_t     operand_b,
  input  kronos_types::word_t     store_data,
  input  kronos_types::word_t     decode_target,
  input  kronos_types::word_t     link_pc,
  input  kronos_types::regsel_t   rd,
  input  logic                    rd_en,
  input  logic                    decode_vld,
  output logic                    decode_rdy,
  output kronos_types::word_t     regwr_data,
  output kronos_types::regsel_t   regwr_sel,
  output logic                    regwr_en,
  output logic                    branch,
  output kronos_types::word_t     branch_target,
  output kronos_types::word_t     data_addr,
  output kronos_types::word_t     data_wr_data,
  output kronos_types::mask_t     data_mask,
  output logic                    data_wr_en,
  output logic                    data_req,
  input  kronos_types::word_t     data_rd_data,
  input  logic                    data_ack
);

  kronos_types::ls_state_t state;
  kronos_types::word_t alu_res;
  logic accept;
  logic is_mem;
  logic equal;
  logic taken;
  logic load_wr;

  // Nothing new is taken while a redirect leaves, the item in decode is wrong-path
  assign decode_rdy = (state == kronos_types::LS_IDLE) && !branch;
  assign accept = decode_vld && decode_rdy;
  assign is_mem = (ex_kind == kronos_types::EX_LOAD) || (ex_kind == kronos_types::EX_STORE);

  assign equal = operand_a == operand_b;
  assign taken = (ex_kind == kronos_types::EX_BRANCH_EQ && equal) ||
                 (ex_kind == kronos_types::EX_BRANCH_NE && !equal) ||
                 (ex_kind == kronos_types::EX_JUMP);

  assign data_mask = '1;

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (alu_op)
      kronos_types::ALU_SUB: alu_res = operand_a - operand_b;
      kronos_types::ALU_AND: alu_res = operand_a & operand_b;
      kronos_types::ALU_OR: alu_res = operand_a | operand_b;
      kronos_types::ALU_XOR: alu_res = operand_a ^ operand_b;
      kronos_types::ALU_PASS_B: alu_res = operand_b;
      default: alu_res = operand_a + operand_b;
    endcase
  end

  // ====================
  // Sequencing
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= kronos_types::LS_IDLE;
      data_req <= 1'b0;
      regwr_en <= 1'b0;
      branch <= 1'b0;
    end else begin
      regwr_en <= 1'b0;
      branch <= 1'b0;
      case (state)
        kronos_types::LS_IDLE: begin
          if (accept && is_mem) begin
            state <= kronos_types::LS_WAIT_ACK;
            data_req <= 1'b1;
          end else if (accept) begin
            // Only ALU and JAL items carry rd_en
            regwr_en <= rd_en;
            branch <= taken;
          end
        end
        kronos_types::LS_WAIT_ACK: begin
          if (data_ack) begin
            data_req <= 1'b0;
            if (data_wr_en) begin
              state <= kronos_types::LS_IDLE;
            end else begin
              state <= kronos_types::LS_WRITEBACK;
              regwr_en <= load_wr;
            end
          end
        end
        default: state <= kronos_types::LS_IDLE;
      endcase
    end
  end

  // Results and bus payload
  always_ff @(posedge clk) begin
    if (accept) begin
      regwr_sel <= rd;
      load_wr <= rd_en;
      regwr_data <= (ex_kind == kronos_types::EX_JUMP) ? link_pc : alu_res;
      branch_target <= decode_target;
      data_addr <= alu_res;
      data_wr_data <= store_data;
      data_wr_en <= ex_kind == kronos_types::EX_STORE;
    end
    if (state == kronos_types::LS_WAIT_ACK && data_ack) regwr_data <= data_rd_data;
  end

endmodule

`default_nettype wire

// File: kronos_id.sv
/* Decode stage: decodes the RV32I subset, reads the register file and builds operands.
   Stalls fetch on a read-after-write against the items in decode and execute. */
`timescale 1ns/1ps
`default_nettype none

module kronos_id (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush,
  input  kronos_types::word_t     fetch_instr,
  input  kronos_types::word_t     fetch_pc,
  input  logic                    fetch_vld,
  output logic                    fetch_rdy,
  input  kronos_types::word_t     regwr_data,
  input  kronos_types::regsel_t   regwr_sel,
  input  logic                    regwr_en,
  output kronos_types::ex_kind_t  ex_kind,
  output kronos_types::alu_op_t   alu_op,
  output kronos_types::word_t     operand_a,
  output kronos_types::word_t     operand_b,
  output kronos_types::word_t     store_data,
  output kronos_types::word_t     branch_target,
  output kronos_types::word_t     link_pc,
  output kronos_types::regsel_t   rd,
  output logic                    rd_en,
  output logic                    decode_vld,
  input  logic                    decode_rdy
);

  kronos_types::word_t regs [32];
  kronos_types::word_t rs1_data;
  kronos_types::word_t rs2_data;
  kronos_types::word_t imm_i;
  kronos_types::word_t imm_s;
  kronos_types::word_t imm_b;
  kronos_types::word_t imm_u;
  kronos_types::word_t imm_j;
  kronos_types::regsel_t rs1;
  kronos_types::regsel_t rs2;
  kronos_types::regsel_t rd_sel;
  kronos_types::regsel_t sb_rd;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic sb_vld;
  logic hit_dec;
  logic hit_ex;
  logic accept;

  kronos_types::ex_kind_t d_kind;
  kronos_types::alu_op_t d_op;
  kronos_types::word_t d_a;
  kronos_types::word_t d_b;
  kronos_types::word_t d_target;
  logic d_rd_en;

  assign opcode = fetch_instr[6:0];
  assign rd_sel = fetch_instr[11:7];
  assign funct3 = fetch_instr[14:12];
  assign rs1 = fetch_instr[19:15];
  assign rs2 = fetch_instr[24:20];
  assign funct7 = fetch_instr[31:25];

  assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
  assign imm_s = {{20{fetch_instr[31]}}, fetch_instr[31:25], fetch_instr[11:7]};
  assign imm_b = {{19{fetch_instr[31]}}, fetch_instr[31], fetch_instr[7],
                  fetch_instr[30:25], fetch_instr[11:8], 1'b0};
  assign imm_u = {fetch_instr[31:12], 12'b0};
  assign imm_j = {{11{fetch_instr[31]}}, fetch_instr[31], fetch_instr[19:12],
                  fetch_instr[20], fetch_instr[30:21], 1'b0};

  // ====================
  // Register file
  // ====================
  // x0 reads as zero, write-back in the same cycle bypasses the array
  assign rs1_data = (rs1 == '0) ? '0 :
                    (regwr_en && regwr_sel == rs1) ? regwr_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (regwr_en && regwr_sel == rs2) ? regwr_data : regs[rs2];

  always_ff @(posedge clk) begin
    if (regwr_en && regwr_sel != '0) regs[regwr_sel] <= regwr_data;
  end

  // ====================
  // Decoder
  // ====================
  always_comb begin
    d_kind = kronos_types::EX_NOP;
    d_op = kronos_types::ALU_ADD;
    d_a = rs1_data;
    d_b = rs2_data;
    d_target = fetch_pc + imm_b;
    d_rd_en = 1'b0;
    case (opcode)
      kronos_types::OPC_OPIMM: begin
        if (funct3 == 3'b000) begin
          d_kind = kronos_types::EX_ALU;
          d_b = imm_i;
          d_rd_en = 1'b1;
        end
      end
      kronos_types::OPC_OP: begin
        d_kind = kronos_types::EX_ALU;
        d_rd_en = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: d_op = kronos_types::ALU_ADD;
          10'b0100000_000: d_op = kronos_types::ALU_SUB;
          10'b0000000_111: d_op = kronos_types::ALU_AND;
          10'b0000000_110: d_op = kronos_types::ALU_OR;
          10'b0000000_100: d_op = kronos_types::ALU_XOR;
          default: begin
            d_kind = kronos_types::EX_NOP;
            d_rd_en = 1'b0;
          end
        endcase
      end
      kronos_types::OPC_LUI: begin
        d_kind = kronos_types::EX_ALU;
        d_op = kronos_types::ALU_PASS_B;
        d_b = imm_u;
        d_rd_en = 1'b1;
      end
      kronos_types::OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          d_kind = kronos_types::EX_LOAD;
          d_b = imm_i;
          d_rd_en = 1'b1;
        end
      end
      kronos_types::OPC_STORE: begin
        if (funct3 == 3'b010) begin
          d_kind = kronos_types::EX_STORE;
          d_b = imm_s;
        end
      end
      kronos_types::OPC_BRANCH: begin
        if (funct3 == 3'b000) d_kind = kronos_types::EX_BRANCH_EQ;
        else if (funct3 == 3'b001) d_kind = kronos_types::EX_BRANCH_NE;
      end
      kronos_types::OPC_JAL: begin
        d_kind = kronos_types::EX_JUMP;
        d_target = fetch_pc + imm_j;
        d_rd_en = 1'b1;
      end
      default: ;
    endcase
    // Writes to x0 are dropped here so they never scoreboard
    d_rd_en = d_rd_en && (rd_sel != '0);
  end

  // ====================
  // Hazards and handshake
  // ====================
  assign hit_dec = decode_vld && rd_en && (rs1 == rd || rs2 == rd);
  assign hit_ex = sb_vld && !regwr_en && (rs1 == sb_rd || rs2 == sb_rd);
  assign fetch_rdy = (!decode_vld || decode_rdy) && !hit_dec && !hit_ex;
  assign accept = fetch_vld && fetch_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      decode_vld <= 1'b0;
      sb_vld <= 1'b0;
    end else begin
      if (flush) decode_vld <= 1'b0;
      else if (accept) decode_vld <= 1'b1;
      else if (decode_rdy) decode_vld <= 1'b0;

      // Scoreboard follows the item into execute until it writes back
      if (decode_vld && decode_rdy) sb_vld <= rd_en;
      else if (regwr_en) sb_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_kind <= d_kind;
      alu_op <= d_op;
      operand_a <= d_a;
      operand_b <= d_b;
      store_data <= rs2_data;
      branch_target <= d_target;
      link_pc <= fetch_pc + 32'd4;
      rd <= rd_sel;
      rd_en <= d_rd_en;
    end
    if (decode_vld && decode_rdy) sb_rd <= rd;
  end

endmodule

`default_nettype wire

// File: kronos_if.sv
/* Fetch stage: program counter, instruction bus requests and a one-entry buffer
   towards decode, with a spare slot for a response that arrives while the buffer is full. */
`timescale 1ns/1ps
`default_nettype none

module kronos_if (
  input  logic                clk,
  input  logic                rst,
  output kronos_types::word_t instr_addr,
  output logic                instr_req,
  input  kronos_types::word_t instr_data,
  input  logic                instr_ack,
  input  logic                branch,
  input  kronos_types::word_t branch_target,
  output kronos_types::word_t fetch_instr,
  output kronos_types::word_t fetch_pc,
  output logic                fetch_vld,
  input  logic                fetch_rdy
);

  kronos_types::word_t pc;
  kronos_types::word_t pend_instr;
  kronos_types::word_t pend_pc;
  logic pend_vld;
  logic drop;
  logic start;
  logic take;
  logic pop;
  logic load_buf;
  logic load_pend;
  logic buf_from_pend;

  assign pop = fetch_vld && fetch_rdy;
  // Response is kept unless it belongs to a squashed path
  assign take = instr_ack && !drop && !branch;
  assign start = !branch && !instr_req && !pend_vld;

  assign buf_from_pend = pop && pend_vld;
  assign load_buf = !branch && (pop ? (pend_vld || take) : (take && !fetch_vld));
  assign load_pend = !branch && take && fetch_vld && !pop;

  // ====================
  // Control
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= kronos_types::BOOT_ADDR;
      instr_req <= 1'b0;
      drop <= 1'b0;
      fetch_vld <= 1'b0;
      pend_vld <= 1'b0;
    end else begin
      if (instr_ack) instr_req <= 1'b0;
      else if (start) instr_req <= 1'b1;

      if (branch) pc <= branch_target;
      else if (start) pc <= pc + 32'd4;

      // Outstanding request on a redirect completes and is thrown away
      if (branch) drop <= instr_req && !instr_ack;
      else if (instr_ack) drop <= 1'b0;

      if (branch) fetch_vld <= 1'b0;
      else if (load_buf) fetch_vld <= 1'b1;
      else if (pop) fetch_vld <= 1'b0;

      if (branch || buf_from_pend) pend_vld <= 1'b0;
      else if (load_pend) pend_vld <= 1'b1;
    end
  end

  // Address and fetched words
  always_ff @(posedge clk) begin
    if (start) instr_addr <= pc;
    if (load_pend) begin
      pend_instr <= instr_data;
      pend_pc <= instr_addr;
    end
    if (load_buf) begin
      fetch_instr <= buf_from_pend ? pend_instr : instr_data;
      fetch_pc <= buf_from_pend ? pend_pc : instr_addr;
    end
  end

endmodule

`default_nettype wire

// File: kronos_types.sv
/* Shared widths, enums, opcodes and boot address for the three-stage RV32I subset core.
   Every design file refers to these by scoped name. */
`default_nettype none

package kronos_types;

  // Data and address word
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regsel_t;
  // Byte enables, always all ones for word accesses
  typedef logic [3:0]  mask_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [2:0] {
    EX_ALU,
    EX_LOAD,
    EX_STORE,
    EX_BRANCH_EQ,
    EX_BRANCH_NE,
    EX_JUMP,
    EX_NOP
  } ex_kind_t;

  typedef enum logic [1:0] {
    LS_IDLE,
    LS_WAIT_ACK,
    LS_WRITEBACK
  } ls_state_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_SERVE_INSTR,
    ARB_SERVE_DATA
  } arb_state_t;

  localparam word_t BOOT_ADDR = 32'h0;

  // RV32I major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage

`default_nettype wire
